//--- design/apb_rx_regs.sv
`timescale 1ns/100ps

module apb_rx_regs #(
  parameter int unsigned BIT_PERIOD_RESET = uart_rx_pkg::default_bit_period
) (
  input  logic                                tb_clk,
  input  logic                                rst,
  input  uart_rx_pkg::apb_req_t               apb_req,
  output logic [uart_rx_pkg::data_width-1:0]  prdata,
  output logic                                pslverr,
  input  uart_rx_pkg::rx_frame_t              frame,
  input  logic                                frame_done,
  output uart_rx_pkg::rx_cfg_t                cfg
);
  import uart_rx_pkg::*;

  reg_addr_e             addr;
  logic                  access;
  logic                  addr_err;
  logic                  ro_err;
  logic                  size_err;
  logic                  acc_err;
  logic                  wr_en;
  logic                  rd_clr;
  logic [data_width-1:0] rd_mux;

  // Status flags and the single word buffer
  logic                  data_ready;
  logic                  framing;
  logic                  overrun;
  logic [data_width-1:0] rx_buf;

  //**************************************************************************
  // Access decode
  //**************************************************************************
  // Access phase of a transfer
  assign access = apb_req.psel && apb_req.penable;
  assign addr   = reg_addr_e'(apb_req.paddr);

  // Read mux and per-address checks
  always_comb begin
    addr_err = 1'b0;
    ro_err   = 1'b0;
    rd_mux   = '0;
    case (addr)
      addr_data_status: begin
        rd_mux = data_width'(data_ready);
        ro_err = apb_req.pwrite;
      end
      addr_error_status: begin
        rd_mux = data_width'({overrun, framing});
        ro_err = apb_req.pwrite;
      end
      addr_period_low:  rd_mux = cfg.bit_period[7:0];
      addr_period_high: rd_mux = data_width'(cfg.bit_period[bit_period_width-1:8]);
      addr_data_size:   rd_mux = data_width'(cfg.data_size);
      addr_rx_data: begin
        rd_mux = rx_buf;
        ro_err = apb_req.pwrite;
      end
      // Holes at 5 and 7
      default: addr_err = 1'b1;
    endcase
  end

  // Size register only takes 5 to 8
  assign size_err = (addr == addr_data_size) && apb_req.pwrite &&
                    ((apb_req.pwdata < data_width'(min_data_size)) ||
                     (apb_req.pwdata > data_width'(max_data_size)));

  assign acc_err = addr_err || ro_err || size_err;

  // Bus outputs are zero outside the access phase
  assign pslverr = access && acc_err;
  assign prdata  = (access && !acc_err && !apb_req.pwrite) ? rd_mux : '0;

  assign wr_en  = access && apb_req.pwrite && !acc_err;
  // Reading the word consumes it
  assign rd_clr = access && !apb_req.pwrite && (addr == addr_rx_data);

  //**************************************************************************
  // Configuration registers
  //**************************************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      cfg.bit_period <= bit_period_width'(BIT_PERIOD_RESET);
      cfg.data_size  <= data_size_width'(max_data_size);
    end else if (wr_en) begin
      case (addr)
        addr_period_low:  cfg.bit_period[7:0] <= apb_req.pwdata;
        // Two top bits of the byte are dropped
        addr_period_high: cfg.bit_period[bit_period_width-1:8] <= apb_req.pwdata[5:0];
        addr_data_size:   cfg.data_size <= apb_req.pwdata[data_size_width-1:0];
        default: ;
      endcase
    end
  end

  //**************************************************************************
  // Status flags
  //**************************************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      data_ready <= 1'b0;
      framing    <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      if (rd_clr) begin
        data_ready <= 1'b0;
        overrun    <= 1'b0;
      end
      if (frame_done) begin
        if (frame.stop_bit) begin
          framing    <= 1'b0;
          data_ready <= 1'b1;
          // Old word never read
          if (data_ready && !rd_clr) begin
            overrun <= 1'b1;
          end
        end else begin
          // Bad stop bit leaves the buffer untouched
          framing <= 1'b1;
        end
      end
    end
  end

  // Newest good word only
  always_ff @(posedge tb_clk) begin
    if (frame_done && frame.stop_bit) begin
      rx_buf <= frame.data;
    end
  end

endmodule

//--- design/apb_uart_rx.sv
`timescale 1ns/100ps

module apb_uart_rx #(
  parameter int unsigned BIT_PERIOD_RESET = uart_rx_pkg::default_bit_period,
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                                tb_clk,
  input  logic                                rst,
  input  logic                                serial_in,
  input  uart_rx_pkg::apb_req_t               apb_req,
  output logic [uart_rx_pkg::data_width-1:0]  prdata,
  output logic                                pslverr
);
  import uart_rx_pkg::*;

  // Configuration and received frame
  rx_cfg_t   cfg;
  rx_frame_t frame;

  // Synchronized serial line
  logic line_sync;

  // FSM strobes
  logic timer_start_half;
  logic timer_start_full;
  logic sample_bit;
  logic sample_stop;
  logic frame_done;

  // Timer status
  logic bit_tick;
  logic last_bit;

  //**************************************************************************
  // Register block
  //**************************************************************************
  apb_rx_regs #(
    .BIT_PERIOD_RESET(BIT_PERIOD_RESET)
  ) apb_rx_regs_inst (
    .tb_clk    (tb_clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .frame     (frame),
    .frame_done(frame_done),
    .cfg       (cfg)
  );

  //**************************************************************************
  // Receive path
  //**************************************************************************
  rx_frame_fsm rx_frame_fsm_inst (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .line_sync       (line_sync),
    .bit_tick        (bit_tick),
    .last_bit        (last_bit),
    .timer_start_half(timer_start_half),
    .timer_start_full(timer_start_full),
    .sample_bit      (sample_bit),
    .sample_stop     (sample_stop),
    .frame_done      (frame_done)
  );

  rx_bit_timer rx_bit_timer_inst (
    .tb_clk          (tb_clk),
    .rst             (rst),
    .cfg             (cfg),
    .timer_start_half(timer_start_half),
    .timer_start_full(timer_start_full),
    .sample_bit      (sample_bit),
    .bit_tick        (bit_tick),
    .last_bit        (last_bit)
  );

  rx_sampler #(
    .SYNC_STAGES(SYNC_STAGES)
  ) rx_sampler_inst (
    .tb_clk     (tb_clk),
    .rst        (rst),
    .serial_in  (serial_in),
    .cfg        (cfg),
    .sample_bit (sample_bit),
    .sample_stop(sample_stop),
    .line_sync  (line_sync),
    .frame      (frame)
  );

endmodule

//--- design/rx_bit_timer.sv
`timescale 1ns/100ps

module rx_bit_timer (
  input  logic                 tb_clk,
  input  logic                 rst,
  input  uart_rx_pkg::rx_cfg_t cfg,
  input  logic                 timer_start_half,
  input  logic                 timer_start_full,
  input  logic                 sample_bit,
  output logic                 bit_tick,
  output logic                 last_bit
);
  import uart_rx_pkg::*;

  logic [bit_period_width-1:0] cycle_cnt;
  logic [bit_period_width-1:0] load_val;
  logic                        running;
  logic [data_size_width-1:0]  bit_cnt;

  //**************************************************************************
  // Cycle counter
  //**************************************************************************
  // Load one less, so the tick lands N cycles after the strobe
  always_comb begin
    if (timer_start_half) begin
      load_val = (cfg.bit_period >> 1) - 1'b1;
    end else begin
      load_val = cfg.bit_period - 1'b1;
    end
  end

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      cycle_cnt <= '0;
      running   <= 1'b0;
    end else if (timer_start_half || timer_start_full) begin
      cycle_cnt <= load_val;
      running   <= 1'b1;
    end else if (running) begin
      if (cycle_cnt == '0) begin
        // One shot until the next load
        running <= 1'b0;
      end else begin
        cycle_cnt <= cycle_cnt - 1'b1;
      end
    end
  end

  assign bit_tick = running && (cycle_cnt == '0);

  //**************************************************************************
  // Data bit counter
  //**************************************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (timer_start_half) begin
      // New frame
      bit_cnt <= '0;
    end else if (sample_bit) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign last_bit = (bit_cnt == cfg.data_size);

endmodule

//--- design/rx_frame_fsm.sv
`timescale 1ns/100ps

module rx_frame_fsm (
  input  logic tb_clk,
  input  logic rst,
  input  logic line_sync,
  input  logic bit_tick,
  input  logic last_bit,
  output logic timer_start_half,
  output logic timer_start_full,
  output logic sample_bit,
  output logic sample_stop,
  output logic frame_done
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_stop,
    st_done
  } state_e;

  state_e state;
  state_e state_next;

  // Line level of the previous cycle, for falling edge detect
  logic line_prev;

  //**************************************************************************
  // State and edge registers
  //**************************************************************************
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      state     <= st_idle;
      line_prev <= 1'b1;
    end else begin
      state     <= state_next;
      line_prev <= line_sync;
    end
  end

  //**************************************************************************
  // Next state and strobes
  //**************************************************************************
  always_comb begin
    state_next       = state;
    timer_start_half = 1'b0;
    timer_start_full = 1'b0;
    sample_bit       = 1'b0;
    sample_stop      = 1'b0;
    frame_done       = 1'b0;
    case (state)
      // Only a falling edge starts a frame, not a line stuck low
      st_idle: begin
        if (line_prev && !line_sync) begin
          timer_start_half = 1'b1;
          state_next       = st_start;
        end
      end
      // Middle of the start bit
      st_start: begin
        if (bit_tick) begin
          if (!line_sync) begin
            timer_start_full = 1'b1;
            state_next       = st_data;
          end else begin
            // Glitch rather than a start bit
            state_next = st_idle;
          end
        end
      end
      // One bit per period until the size is reached
      st_data: begin
        if (last_bit) begin
          state_next = st_stop;
        end else if (bit_tick) begin
          sample_bit       = 1'b1;
          timer_start_full = 1'b1;
        end
      end
      // Timer still runs from the last data bit
      st_stop: begin
        if (bit_tick) begin
          sample_stop = 1'b1;
          state_next  = st_done;
        end
      end
      st_done: begin
        frame_done = 1'b1;
        state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

//--- design/rx_sampler.sv
`timescale 1ns/100ps

module rx_sampler #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                    tb_clk,
  input  logic                    rst,
  input  logic                    serial_in,
  input  uart_rx_pkg::rx_cfg_t    cfg,
  input  logic                    sample_bit,
  input  logic                    sample_stop,
  output logic                    line_sync,
  output uart_rx_pkg::rx_frame_t  frame
);
  import uart_rx_pkg::*;

  // At least two stages
  logic [SYNC_STAGES-1:0]     sync_q;
  logic [data_width-1:0]      shift_q;
  logic                       stop_q;
  logic [data_size_width-1:0] shift_amt;

  //**************************************************************************
  // Line synchronizer
  //**************************************************************************
  // Idle line is high
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], serial_in};
    end
  end

  assign line_sync = sync_q[SYNC_STAGES-1];

  //**************************************************************************
  // Data and stop capture
  //**************************************************************************
  // LSB first, so bits enter at the top and move down
  always_ff @(posedge tb_clk) begin
    if (sample_bit) begin
      shift_q <= {line_sync, shift_q[data_width-1:1]};
    end
  end

  always_ff @(posedge tb_clk) begin
    if (sample_stop) begin
      stop_q <= line_sync;
    end
  end

  // Short words sit high in the register
  assign shift_amt = data_size_width'(max_data_size) - cfg.data_size;

  // Zero fill clears the bits above the word
  assign frame.data     = shift_q >> shift_amt;
  assign frame.stop_bit = stop_q;

endmodule

//--- design/uart_rx_pkg.sv
package uart_rx_pkg;

  //**************************************************************************
  // Widths
  //**************************************************************************
  // APB side
  localparam int unsigned apb_addr_width = 3;
  localparam int unsigned data_width = 8;

  // Receiver configuration fields
  localparam int unsigned bit_period_width = 14;
  localparam int unsigned data_size_width = 4;

  // Accepted word sizes in bits
  localparam int unsigned min_data_size = 5;
  localparam int unsigned max_data_size = 8;

  //**************************************************************************
  // Register map
  //**************************************************************************
  // Addresses 5 and 7 are holes in the map
  typedef enum logic [apb_addr_width-1:0] {
    addr_data_status  = 3'd0,
    addr_error_status = 3'd1,
    addr_period_low   = 3'd2,
    addr_period_high  = 3'd3,
    addr_data_size    = 3'd4,
    addr_rx_data      = 3'd6
  } reg_addr_e;

  // Bit period out of reset, in clock cycles
  localparam int unsigned default_bit_period = 10;

  //**************************************************************************
  // Shared structs
  //**************************************************************************
  // Receiver configuration from the register block
  typedef struct packed {
    logic [bit_period_width-1:0] bit_period;
    logic [data_size_width-1:0]  data_size;
  } rx_cfg_t;

  // Received frame, data right-justified
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  stop_bit;
  } rx_frame_t;

  // APB request from the bus master
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [data_width-1:0]     pwdata;
  } apb_req_t;

endpackage

//--- project.f
+incdir+test
design/uart_rx_pkg.sv
design/rx_bit_timer.sv
design/rx_sampler.sv
design/rx_frame_fsm.sv
design/apb_rx_regs.sv
design/apb_uart_rx.sv
test/tb_apb_uart_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the receiver testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_apb_uart_rx -f project.f -o sim_tb_apb_uart_rx &&
./obj_dir/sim_tb_apb_uart_rx ||
{ echo "Simulation run failed"; exit 1; }

//--- test/tb_apb_uart_rx_tasks.svh
`ifndef TB_APB_UART_RX_TASKS_SVH
`define TB_APB_UART_RX_TASKS_SVH

//**************************************************************************
// APB transfers
//**************************************************************************
// Setup phase then access phase, each driven on a falling edge
task automatic apb_transfer(
  input  logic                      write,
  input  logic [apb_addr_width-1:0] addr,
  input  logic [data_width-1:0]     wdata,
  output logic [data_width-1:0]     rdata,
  output logic                      err
);
  @(negedge tb_clk);
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = write;
  apb_req.paddr   = addr;
  apb_req.pwdata  = wdata;
  @(negedge tb_clk);
  apb_req.penable = 1'b1;
  // Response taken on the edge that ends the access phase
  @(posedge tb_clk);
  rdata = prdata;
  err   = pslverr;
  @(negedge tb_clk);
  apb_req = '0;
endtask

// Read that must succeed with a known value
task automatic read_expect(
  input logic [apb_addr_width-1:0] addr,
  input logic [data_width-1:0]     want,
  input string                     what
);
  logic [data_width-1:0] data;
  logic                  err;
  apb_transfer(1'b0, addr, 8'h00, data, err);
  check_value({what, " pslverr"}, {7'b0, err}, 8'h00);
  check_value(what, data, want);
endtask

// Write that must be accepted
task automatic write_ok(
  input logic [apb_addr_width-1:0] addr,
  input logic [data_width-1:0]     data,
  input string                     what
);
  logic [data_width-1:0] rdata;
  logic                  err;
  apb_transfer(1'b1, addr, data, rdata, err);
  check_value({what, " pslverr"}, {7'b0, err}, 8'h00);
endtask

//**************************************************************************
// Serial line and status polling
//**************************************************************************
// Start bit, size data bits LSB first, stop bit, one idle period
task automatic send_frame(
  input logic [data_width-1:0] data,
  input int                    size,
  input int                    period,
  input logic                  stop
);
  int i;
  @(negedge tb_clk);
  serial_in = 1'b0;
  repeat (period) @(negedge tb_clk);
  for (i = 0; i < size; i++) begin
    serial_in = data[i];
    repeat (period) @(negedge tb_clk);
  end
  serial_in = stop;
  repeat (period) @(negedge tb_clk);
  // Back to idle high
  serial_in = 1'b1;
  repeat (period) @(negedge tb_clk);
endtask

// Poll a status register until the masked bits match
task automatic wait_status(
  input logic [apb_addr_width-1:0] addr,
  input logic [data_width-1:0]     mask,
  input logic [data_width-1:0]     want,
  input string                     what
);
  logic [data_width-1:0] data;
  logic                  err;
  int                    polls;
  polls = 0;
  apb_transfer(1'b0, addr, 8'h00, data, err);
  while ((data & mask) != want) begin
    polls++;
    if (polls > poll_limit) begin
      fail_run($sformatf("Timeout at %0t waiting for %s", $time, what));
    end
    apb_transfer(1'b0, addr, 8'h00, data, err);
  end
endtask

`endif

//--- test/tb_apb_uart_rx.sv
`timescale 1ns/100ps

module tb_apb_uart_rx;
  import uart_rx_pkg::*;

  //**************************************************************************
  // Testbench constants
  //**************************************************************************
  localparam int clk_half = 20;
  localparam int reset_cycles = 16;
  localparam int reset_bit_period = 10;
  // Status polls before a wait gives up
  localparam int poll_limit = 64;

  logic                  tb_clk;
  logic                  rst;
  logic                  serial_in;
  apb_req_t              apb_req;
  logic [data_width-1:0] prdata;
  logic                  pslverr;

  // Random frame words
  integer                seed;
  logic [data_width-1:0] word;
  logic [data_width-1:0] word_b;

  // 40 ns clock
  initial tb_clk = 1'b0;
  always #(clk_half) tb_clk = ~tb_clk;

  apb_uart_rx #(
    .BIT_PERIOD_RESET(reset_bit_period),
    .SYNC_STAGES     (2)
  ) apb_uart_rx_inst (
    .tb_clk   (tb_clk),
    .rst      (rst),
    .serial_in(serial_in),
    .apb_req  (apb_req),
    .prdata   (prdata),
    .pslverr  (pslverr)
  );

  //**************************************************************************
  // Failure reporting and checks
  //**************************************************************************
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] want);
    assert (got === want) else begin
      fail_run($sformatf("MISMATCH at %0t: %s read %02h, expected %02h",
                         $time, what, got, want));
    end
  endtask

  `include "tb_apb_uart_rx_tasks.svh"

  // Access that must end in a slave error with zero read data
  task automatic expect_slave_error(
    input logic                      write,
    input logic [apb_addr_width-1:0] addr,
    input logic [data_width-1:0]     wdata,
    input string                     what
  );
    logic [data_width-1:0] data;
    logic                  err;
    apb_transfer(write, addr, wdata, data, err);
    check_value({what, " pslverr"}, {7'b0, err}, 8'h01);
    check_value({what, " prdata"}, data, 8'h00);
  endtask

  // Period split over the low and high registers
  task automatic set_period(input int period);
    write_ok(addr_period_low, 8'(period), "period low write");
    write_ok(addr_period_high, 8'(period >> 8), "period high write");
  endtask

  // One good frame, then read it back and check the flags
  task automatic good_frame(input int size, input int period);
    logic [data_width-1:0] sent;
    logic [data_width-1:0] mask;
    sent = 8'($random(seed));
    // Bits above the word size read as zero
    mask = 8'hff >> (8 - size);
    send_frame(sent, size, period, 1'b1);
    wait_status(addr_data_status, 8'h01, 8'h01, "data ready");
    read_expect(addr_error_status, 8'h00, "error status after good frame");
    read_expect(addr_rx_data, sent & mask,
                $sformatf("%0d-bit word at period %0d", size, period));
    read_expect(addr_data_status, 8'h00, "data status after data read");
  endtask

  //**************************************************************************
  // Test sequence
  //**************************************************************************
  initial begin
    seed      = 32'hec779aa9;
    rst       = 1'b1;
    serial_in = 1'b1;
    apb_req   = '0;
    repeat (reset_cycles) @(negedge tb_clk);
    rst = 1'b0;

    // Idle bus and reset values
    check_value("prdata when idle", prdata, 8'h00);
    check_value("pslverr when idle", {7'b0, pslverr}, 8'h00);
    read_expect(addr_period_low, 8'(reset_bit_period), "period low after reset");
    read_expect(addr_period_high, 8'(reset_bit_period >> 8), "period high after reset");
    read_expect(addr_data_size, 8'd8, "data size after reset");
    read_expect(addr_data_status, 8'h00, "data status after reset");
    read_expect(addr_error_status, 8'h00, "error status after reset");

    // Full words at two periods
    set_period(5);
    good_frame(8, 5);
    set_period(10);
    good_frame(8, 10);

    // Short words
    write_ok(addr_data_size, 8'd5, "data size 5 write");
    read_expect(addr_data_size, 8'd5, "data size 5");
    good_frame(5, 10);
    write_ok(addr_data_size, 8'd7, "data size 7 write");
    good_frame(7, 10);
    write_ok(addr_data_size, 8'd8, "data size 8 write");

    // Stop bit low, then recovery on a good frame
    word = 8'($random(seed));
    send_frame(word, 8, 10, 1'b0);
    wait_status(addr_error_status, 8'h01, 8'h01, "framing flag");
    read_expect(addr_data_status, 8'h00, "data status after framing error");
    read_expect(addr_error_status, 8'h01, "error status after framing error");
    good_frame(8, 10);

    // Two words with no read between
    word = 8'($random(seed));
    send_frame(word, 8, 10, 1'b1);
    wait_status(addr_data_status, 8'h01, 8'h01, "first word of overrun pair");
    word_b = 8'($random(seed));
    // Second word must differ from the first
    if (word_b == word) begin
      word_b = ~word;
    end
    send_frame(word_b, 8, 10, 1'b1);
    wait_status(addr_error_status, 8'h02, 8'h02, "overrun flag");
    read_expect(addr_error_status, 8'h02, "error status with overrun");
    read_expect(addr_rx_data, word_b, "newest word after overrun");
    read_expect(addr_error_status, 8'h00, "error status after overrun read");
    read_expect(addr_data_status, 8'h00, "data status after overrun read");

    // Holes, read-only registers and a bad size
    expect_slave_error(1'b0, 3'd5, 8'h00, "read of address 5");
    expect_slave_error(1'b1, 3'd5, 8'h5a, "write of address 5");
    expect_slave_error(1'b0, 3'd7, 8'h00, "read of address 7");
    expect_slave_error(1'b1, addr_rx_data, 8'h33, "write of received data");
    expect_slave_error(1'b1, addr_data_status, 8'h01, "write of data status");
    expect_slave_error(1'b1, addr_data_size, 8'd9, "data size 9 write");
    read_expect(addr_data_size, 8'd8, "data size kept after bad write");

    // Upper period byte keeps 6 bits and the period becomes 0x12c
    write_ok(addr_period_low, 8'h2c, "period low 0x2c write");
    write_ok(addr_period_high, 8'hc1, "period high 0xc1 write");
    read_expect(addr_period_high, 8'h01, "period high top bits dropped");
    read_expect(addr_period_low, 8'h2c, "period low readback");
    good_frame(8, 300);

    $display("All tests passed");
    $finish;
  end

endmodule
